// ==== hw/wh_mem_macros.svh ====
`ifndef WH_MEM_MACROS_SVH
`define WH_MEM_MACROS_SVH

// flit is one data word
`define WH_FLIT_WIDTH 32

// words per block, also data flits per packet and mask width
`define WH_BLOCK_WORDS 4

`define WH_NUM_CLIENTS 2

`define WH_MEM_WORDS 256 // 64 blocks

// block address, log2 of WH_MEM_WORDS / WH_BLOCK_WORDS
`define WH_BLOCK_ADDR_WIDTH 6

`define WH_CID_WIDTH 1
`define WH_LEN_WIDTH 4 // flits after the header

`endif

// ==== hw/wh_mem_pkg.sv ====
`include "wh_mem_macros.svh"

package wh_mem_pkg;

  typedef enum logic [1:0] {
    op_read         = 2'd0,
    op_write        = 2'd1,
    op_write_masked = 2'd2
  } wh_opcode_e;

  // one flit wide, len counts the flits behind it
  typedef struct packed {
    logic [`WH_FLIT_WIDTH-2-2*`WH_CID_WIDTH-`WH_LEN_WIDTH-1:0] unused;
    wh_opcode_e                  opcode;
    logic [`WH_CID_WIDTH-1:0]    src_cid;
    logic [`WH_CID_WIDTH-1:0]    dst_cid; // fill return target
    logic [`WH_LEN_WIDTH-1:0]    len;
  } wh_header_s;

endpackage

// ==== hw/wh_link_if.sv ====
`timescale 1ns/1ps
`include "wh_mem_macros.svh"

// forward carries request packets, reverse carries fills
interface wh_link_if;

  logic                      fwd_v;
  logic [`WH_FLIT_WIDTH-1:0] fwd_data;
  logic                      fwd_ready;

  logic                      rev_v;
  logic [`WH_FLIT_WIDTH-1:0] rev_data;
  logic                      rev_ready;

  modport client (
    output fwd_v, fwd_data, rev_ready,
    input  fwd_ready, rev_v, rev_data
  );

  modport mem (
    input  fwd_v, fwd_data, rev_ready,
    output fwd_ready, rev_v, rev_data
  );

endinterface

// ==== hw/wh_block_client.sv ====
`timescale 1ns/1ps
`include "wh_mem_macros.svh"

module wh_block_client #(
  parameter int cid_p = 0
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         req_v_i,
  output logic                                         req_ready_o,
  input  wh_mem_pkg::wh_opcode_e                       req_op_i,
  input  logic [`WH_BLOCK_ADDR_WIDTH-1:0]              req_addr_i,
  input  logic [`WH_BLOCK_WORDS-1:0]                   req_mask_i,
  input  logic [`WH_BLOCK_WORDS*`WH_FLIT_WIDTH-1:0]    req_wdata_i,
  output logic                                         resp_v_o,
  output logic [`WH_BLOCK_WORDS*`WH_FLIT_WIDTH-1:0]    resp_rdata_o,
  wh_link_if.client                                    link
);

  localparam int cnt_width_lp = $clog2(`WH_BLOCK_WORDS);
  localparam int len_width_lp = `WH_LEN_WIDTH;
  localparam int cid_width_lp = `WH_CID_WIDTH;

  typedef enum logic [2:0] {
    RESET, IDLE, SEND_HDR, SEND_ADDR, SEND_MASK, SEND_DATA, RECV_HDR, RECV_DATA
  } state_e;

  state_e                                       state_r, state_n;
  wh_mem_pkg::wh_opcode_e                       op_r;
  logic [`WH_BLOCK_ADDR_WIDTH-1:0]              addr_r;
  logic [`WH_BLOCK_WORDS-1:0]                   mask_r;
  logic [`WH_BLOCK_WORDS*`WH_FLIT_WIDTH-1:0]    wdata_r;
  logic [`WH_BLOCK_WORDS*`WH_FLIT_WIDTH-1:0]    rdata_r;
  logic [cnt_width_lp-1:0]                      cnt_r;
  logic                                         resp_v_r;
  logic                                         last_word;
  logic                                         fwd_hs, rev_hs;
  wh_mem_pkg::wh_header_s                       hdr;

  assign fwd_hs    = link.fwd_v & link.fwd_ready;
  assign rev_hs    = link.rev_v & link.rev_ready;
  assign last_word = (cnt_r == cnt_width_lp'(`WH_BLOCK_WORDS-1));

  assign req_ready_o    = (state_r == IDLE);
  assign resp_v_o       = resp_v_r;
  assign resp_rdata_o   = rdata_r;
  assign link.rev_ready = (state_r == RECV_HDR) || (state_r == RECV_DATA);

  always_comb begin
    hdr         = '0;
    hdr.opcode  = op_r;
    hdr.src_cid = cid_width_lp'(cid_p);
    hdr.dst_cid = cid_width_lp'(cid_p);
    case (op_r)
      wh_mem_pkg::op_read:  hdr.len = len_width_lp'(1);
      wh_mem_pkg::op_write: hdr.len = len_width_lp'(1 + `WH_BLOCK_WORDS);
      default:              hdr.len = len_width_lp'(2 + `WH_BLOCK_WORDS); // addr + mask
    endcase
  end

  always_comb begin
    link.fwd_v    = 1'b0;
    link.fwd_data = '0;
    case (state_r)
      SEND_HDR: begin
        link.fwd_v    = 1'b1;
        link.fwd_data = hdr;
      end
      SEND_ADDR: begin
        link.fwd_v                                  = 1'b1;
        link.fwd_data[`WH_BLOCK_ADDR_WIDTH-1:0]     = addr_r;
      end
      SEND_MASK: begin
        link.fwd_v                             = 1'b1;
        link.fwd_data[`WH_BLOCK_WORDS-1:0]     = mask_r;
      end
      SEND_DATA: begin
        link.fwd_v    = 1'b1;
        link.fwd_data = wdata_r[cnt_r*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH];
      end
      default: ;
    endcase
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      RESET: state_n = IDLE;
      IDLE: if (req_v_i) state_n = SEND_HDR;
      SEND_HDR: if (fwd_hs) state_n = SEND_ADDR;
      SEND_ADDR: begin
        if (fwd_hs) begin
          case (op_r)
            wh_mem_pkg::op_read:         state_n = RECV_HDR;
            wh_mem_pkg::op_write_masked: state_n = SEND_MASK;
            default:                     state_n = SEND_DATA;
          endcase
        end
      end
      SEND_MASK: if (fwd_hs) state_n = SEND_DATA;
      SEND_DATA: if (fwd_hs && last_word) state_n = IDLE;
      RECV_HDR: if (rev_hs) state_n = RECV_DATA; // fill header, nothing to keep
      RECV_DATA: if (rev_hs && last_word) state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= RESET;
      op_r     <= wh_mem_pkg::op_read;
      cnt_r    <= '0;
      resp_v_r <= 1'b0;
    end else begin
      state_r  <= state_n;
      resp_v_r <= (state_r == RECV_DATA) && rev_hs && last_word;
      if (req_v_i && req_ready_o) begin
        op_r <= req_op_i;
      end
      if ((state_r == SEND_DATA && fwd_hs) || (state_r == RECV_DATA && rev_hs)) begin
        cnt_r <= last_word ? '0 : cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      addr_r  <= req_addr_i;
      mask_r  <= req_mask_i;
      wdata_r <= req_wdata_i;
    end
    if (state_r == RECV_DATA && rev_hs) begin
      rdata_r[cnt_r*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH] <= link.rev_data;
    end
  end

  // arbiter must only steer fills to the client that asked
  a_rev_only_when_waiting: assert property (@(posedge clk_i) disable iff (reset_i)
    link.rev_v |-> (state_r == RECV_HDR || state_r == RECV_DATA));

endmodule

// ==== hw/wh_packet_arbiter.sv ====
`timescale 1ns/1ps
`include "wh_mem_macros.svh"

module wh_packet_arbiter (
  input  logic       clk_i,
  input  logic       reset_i,
  wh_link_if.mem     client_link [`WH_NUM_CLIENTS],
  wh_link_if.client  mem_link
);

  localparam int n_lp         = `WH_NUM_CLIENTS;
  localparam int cid_width_lp = `WH_CID_WIDTH;

  logic [n_lp-1:0]               fwd_v_a;
  logic [`WH_FLIT_WIDTH-1:0]     fwd_data_a [n_lp];
  logic [n_lp-1:0]               rev_ready_a;
  logic [n_lp-1:0]               fwd_gnt;
  logic [n_lp-1:0]               rev_sel;

  logic                          fwd_busy_r;
  logic [cid_width_lp-1:0]       grant_r; // current or last winner
  logic [`WH_LEN_WIDTH-1:0]      fwd_cnt_r;
  logic [cid_width_lp-1:0]       pick, fwd_idx;
  logic                          any_v;
  logic                          fwd_hs, fwd_last;
  wh_mem_pkg::wh_header_s        fwd_hdr;

  logic                          rev_busy_r;
  logic [cid_width_lp-1:0]       rev_dst_r;
  logic [`WH_LEN_WIDTH-1:0]      rev_cnt_r;
  logic [cid_width_lp-1:0]       rev_idx;
  logic                          rev_hs;
  wh_mem_pkg::wh_header_s        rev_hdr;

  for (genvar i = 0; i < n_lp; i++) begin : g_port
    assign fwd_v_a[i]    = client_link[i].fwd_v;
    assign fwd_data_a[i] = client_link[i].fwd_data;
    assign rev_ready_a[i] = client_link[i].rev_ready;

    assign fwd_gnt[i] = (fwd_idx == cid_width_lp'(i)) && (fwd_busy_r || any_v);
    assign rev_sel[i] = (rev_idx == cid_width_lp'(i));

    assign client_link[i].fwd_ready = fwd_gnt[i] & mem_link.fwd_ready;
    assign client_link[i].rev_v     = rev_sel[i] & mem_link.rev_v;
    assign client_link[i].rev_data  = mem_link.rev_data; // broadcast, rev_v qualifies
  end

  // round robin, search starts after the last winner
  always_comb begin
    int j;
    pick  = grant_r;
    any_v = 1'b0;
    for (int k = 1; k <= n_lp; k++) begin
      j = (int'(grant_r) + k) % n_lp;
      if (!any_v && fwd_v_a[j]) begin
        pick  = cid_width_lp'(j);
        any_v = 1'b1;
      end
    end
  end

  assign fwd_idx          = fwd_busy_r ? grant_r : pick;
  assign mem_link.fwd_v    = fwd_v_a[fwd_idx];
  assign mem_link.fwd_data = fwd_data_a[fwd_idx];
  assign fwd_hdr          = mem_link.fwd_data;
  assign fwd_hs           = mem_link.fwd_v & mem_link.fwd_ready;
  assign fwd_last         = fwd_busy_r && (fwd_cnt_r == `WH_LEN_WIDTH'(1));

  // fill packets go to the client named in the header
  assign rev_hdr            = mem_link.rev_data;
  assign rev_idx            = rev_busy_r ? rev_dst_r : rev_hdr.dst_cid;
  assign mem_link.rev_ready = rev_ready_a[rev_idx];
  assign rev_hs             = mem_link.rev_v & mem_link.rev_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fwd_busy_r <= 1'b0;
      grant_r    <= cid_width_lp'(n_lp-1); // client 0 wins first
      fwd_cnt_r  <= '0;
      rev_busy_r <= 1'b0;
      rev_dst_r  <= '0;
      rev_cnt_r  <= '0;
    end else begin
      if (fwd_hs) begin
        if (!fwd_busy_r) begin
          fwd_busy_r <= (fwd_hdr.len != '0);
          grant_r    <= pick;
          fwd_cnt_r  <= fwd_hdr.len;
        end else begin
          fwd_cnt_r <= fwd_cnt_r - 1'b1;
          if (fwd_last) fwd_busy_r <= 1'b0;
        end
      end
      if (rev_hs) begin
        if (!rev_busy_r) begin
          rev_busy_r <= (rev_hdr.len != '0);
          rev_dst_r  <= rev_hdr.dst_cid;
          rev_cnt_r  <= rev_hdr.len;
        end else begin
          rev_cnt_r <= rev_cnt_r - 1'b1;
          if (rev_cnt_r == `WH_LEN_WIDTH'(1)) rev_busy_r <= 1'b0;
        end
      end
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(fwd_gnt));

  // grant held from header to last flit
  a_gnt_locked: assert property (@(posedge clk_i) disable iff (reset_i)
    (fwd_hs && !fwd_last) |=> (fwd_gnt == $past(fwd_gnt)));

endmodule

// ==== hw/wh_test_mem.sv ====
`timescale 1ns/1ps
`include "wh_mem_macros.svh"

module wh_test_mem (
  input  logic   clk_i,
  input  logic   reset_i,
  wh_link_if.mem link
);

  localparam int cnt_width_lp  = $clog2(`WH_BLOCK_WORDS);
  localparam int word_width_lp = $clog2(`WH_MEM_WORDS);
  localparam int len_width_lp  = `WH_LEN_WIDTH;

  typedef enum logic [2:0] {
    RESET,
    READY,
    RECV_ADDR,
    RECV_MASK,
    RECV_DATA,
    SEND_FILL_HEADER,
    SEND_FILL_DATA
  } mem_state_e;

  mem_state_e                        mem_state_r, mem_state_n;
  wh_mem_pkg::wh_opcode_e            opcode_r, opcode_n;
  logic [`WH_CID_WIDTH-1:0]          src_cid_r, src_cid_n;
  logic [`WH_BLOCK_ADDR_WIDTH-1:0]   addr_r, addr_n;
  logic [`WH_BLOCK_WORDS-1:0]        mask_r, mask_n;
  logic [cnt_width_lp-1:0]           cnt_r;
  logic                              cnt_up, cnt_clear, cnt_last;

  logic [`WH_FLIT_WIDTH-1:0]         mem_r [`WH_MEM_WORDS];
  logic [word_width_lp-1:0]          word_addr;
  logic                              mem_we;

  wh_mem_pkg::wh_header_s            hdr_in, hdr_out;

  assign word_addr = {addr_r, cnt_r}; // block * 4 + flit count
  assign cnt_last  = (cnt_r == cnt_width_lp'(`WH_BLOCK_WORDS-1));
  assign hdr_in    = link.fwd_data;

  always_comb begin
    hdr_out         = '0;
    hdr_out.opcode  = wh_mem_pkg::op_read;
    hdr_out.dst_cid = src_cid_r;
    hdr_out.len     = len_width_lp'(`WH_BLOCK_WORDS);
  end

  always_comb begin
    link.fwd_ready = 1'b0;
    link.rev_v     = 1'b0;
    link.rev_data  = '0;
    mem_state_n    = mem_state_r;
    opcode_n       = opcode_r;
    src_cid_n      = src_cid_r;
    addr_n         = addr_r;
    mask_n         = mask_r;
    cnt_up         = 1'b0;
    cnt_clear      = 1'b0;
    mem_we         = 1'b0;

    case (mem_state_r)
      RESET: mem_state_n = READY;

      READY: begin
        link.fwd_ready = 1'b1;
        if (link.fwd_v) begin
          opcode_n    = hdr_in.opcode;
          src_cid_n   = hdr_in.src_cid;
          mem_state_n = RECV_ADDR;
        end
      end

      RECV_ADDR: begin
        link.fwd_ready = 1'b1;
        if (link.fwd_v) begin
          addr_n = link.fwd_data[`WH_BLOCK_ADDR_WIDTH-1:0];
          mask_n = '1; // plain write stores every word
          case (opcode_r)
            wh_mem_pkg::op_read:         mem_state_n = SEND_FILL_HEADER;
            wh_mem_pkg::op_write:        mem_state_n = RECV_DATA;
            wh_mem_pkg::op_write_masked: mem_state_n = RECV_MASK;
            default:                     mem_state_n = READY;
          endcase
        end
      end

      RECV_MASK: begin
        link.fwd_ready = 1'b1;
        if (link.fwd_v) begin
          mask_n      = link.fwd_data[`WH_BLOCK_WORDS-1:0];
          mem_state_n = RECV_DATA;
        end
      end

      RECV_DATA: begin
        link.fwd_ready = 1'b1;
        if (link.fwd_v) begin
          mem_we      = mask_r[cnt_r];
          cnt_up      = !cnt_last;
          cnt_clear   = cnt_last;
          mem_state_n = cnt_last ? READY : RECV_DATA;
        end
      end

      SEND_FILL_HEADER: begin
        link.rev_v    = 1'b1;
        link.rev_data = hdr_out;
        if (link.rev_ready) mem_state_n = SEND_FILL_DATA;
      end

      SEND_FILL_DATA: begin
        link.rev_v    = 1'b1;
        link.rev_data = mem_r[word_addr];
        if (link.rev_ready) begin
          cnt_up      = !cnt_last;
          cnt_clear   = cnt_last;
          mem_state_n = cnt_last ? READY : SEND_FILL_DATA;
        end
      end

      default: mem_state_n = READY;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      mem_r[word_addr] <= link.fwd_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_state_r <= RESET;
      opcode_r    <= wh_mem_pkg::op_read;
      src_cid_r   <= '0;
      addr_r      <= '0;
      mask_r      <= '0;
      cnt_r       <= '0;
    end else begin
      mem_state_r <= mem_state_n;
      opcode_r    <= opcode_n;
      src_cid_r   <= src_cid_n;
      addr_r      <= addr_n;
      mask_r      <= mask_n;
      if (cnt_clear) begin
        cnt_r <= '0;
      end else if (cnt_up) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  // header from a client must carry a known opcode
  a_opcode_defined: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_state_r == READY && link.fwd_v) |=>
      (opcode_r inside {wh_mem_pkg::op_read, wh_mem_pkg::op_write,
                        wh_mem_pkg::op_write_masked}));

endmodule

// ==== hw/wh_mem_top.sv ====
`timescale 1ns/1ps
`include "wh_mem_macros.svh"

module wh_mem_top (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  input  logic [`WH_NUM_CLIENTS-1:0]                               req_v_i,
  output logic [`WH_NUM_CLIENTS-1:0]                               req_ready_o,
  input  wh_mem_pkg::wh_opcode_e [`WH_NUM_CLIENTS-1:0]             req_op_i,
  input  logic [`WH_NUM_CLIENTS-1:0][`WH_BLOCK_ADDR_WIDTH-1:0]     req_addr_i,
  input  logic [`WH_NUM_CLIENTS-1:0][`WH_BLOCK_WORDS-1:0]          req_mask_i,
  input  logic [`WH_NUM_CLIENTS-1:0]
               [`WH_BLOCK_WORDS*`WH_FLIT_WIDTH-1:0]                req_wdata_i,
  output logic [`WH_NUM_CLIENTS-1:0]                               resp_v_o,
  output logic [`WH_NUM_CLIENTS-1:0]
               [`WH_BLOCK_WORDS*`WH_FLIT_WIDTH-1:0]                resp_rdata_o
);

  wh_link_if client_link [`WH_NUM_CLIENTS] ();
  wh_link_if mem_link ();

  // one refill engine per client id
  for (genvar g = 0; g < `WH_NUM_CLIENTS; g++) begin : g_client
    wh_block_client #(
      .cid_p(g)
    ) client (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_v_i      (req_v_i[g]),
      .req_ready_o  (req_ready_o[g]),
      .req_op_i     (req_op_i[g]),
      .req_addr_i   (req_addr_i[g]),
      .req_mask_i   (req_mask_i[g]),
      .req_wdata_i  (req_wdata_i[g]),
      .resp_v_o     (resp_v_o[g]),
      .resp_rdata_o (resp_rdata_o[g]),
      .link         (client_link[g])
    );
  end

  wh_packet_arbiter arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .client_link (client_link),
    .mem_link    (mem_link)
  );

  wh_test_mem test_mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .link    (mem_link)
  );

endmodule

// ==== test/tb_wh_mem.sv ====
`timescale 1ns/1ps
`include "wh_mem_macros.svh"

module tb_wh_mem;

  localparam int n_lp           = `WH_NUM_CLIENTS;
  localparam int block_bits_lp  = `WH_BLOCK_WORDS * `WH_FLIT_WIDTH;
  localparam int num_blocks_lp  = `WH_MEM_WORDS / `WH_BLOCK_WORDS;
  localparam int timeout_cycles = 200;

  logic                                           clk_i;
  logic                                           reset_i;
  logic [n_lp-1:0]                                req_v_i;
  logic [n_lp-1:0]                                req_ready_o;
  wh_mem_pkg::wh_opcode_e [n_lp-1:0]              req_op_i;
  logic [n_lp-1:0][`WH_BLOCK_ADDR_WIDTH-1:0]      req_addr_i;
  logic [n_lp-1:0][`WH_BLOCK_WORDS-1:0]           req_mask_i;
  logic [n_lp-1:0][block_bits_lp-1:0]             req_wdata_i;
  logic [n_lp-1:0]                                resp_v_o;
  logic [n_lp-1:0][block_bits_lp-1:0]             resp_rdata_o;

  logic [`WH_FLIT_WIDTH-1:0] model_mem [`WH_MEM_WORDS];
  bit                        written [num_blocks_lp];
  logic [block_bits_lp-1:0]  exp_block [n_lp]; // one read in flight per client
  bit                        exp_pending [n_lp];
  string                     exp_name [n_lp];
  integer                    seed;
  int                        error_count;
  int                        timeout_count;

  wh_mem_top UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_v_i      (req_v_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_mask_i   (req_mask_i),
    .req_wdata_i  (req_wdata_i),
    .resp_v_o     (resp_v_o),
    .resp_rdata_o (resp_rdata_o)
  );

  always #4 clk_i = ~clk_i;

  // word 0 of the block sits in the low bits
  function automatic logic [block_bits_lp-1:0] expected_block(input int addr);
    logic [block_bits_lp-1:0] blk;
    blk = '0;
    for (int i = 0; i < `WH_BLOCK_WORDS; i++) begin
      blk[i*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH] = model_mem[addr*`WH_BLOCK_WORDS + i];
    end
    return blk;
  endfunction

  function automatic void model_write(input int addr, input logic [`WH_BLOCK_WORDS-1:0] mask,
                                      input logic [block_bits_lp-1:0] data);
    for (int i = 0; i < `WH_BLOCK_WORDS; i++) begin
      if (mask[i]) model_mem[addr*`WH_BLOCK_WORDS + i] = data[i*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH];
    end
  endfunction

  function automatic logic [block_bits_lp-1:0] random_block();
    logic [block_bits_lp-1:0] blk;
    for (int i = 0; i < `WH_BLOCK_WORDS; i++) begin
      blk[i*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH] = $random(seed);
    end
    return blk;
  endfunction

  task automatic send_request(input int k, input wh_mem_pkg::wh_opcode_e op, input int addr,
                              input logic [`WH_BLOCK_WORDS-1:0] mask,
                              input logic [block_bits_lp-1:0] data, output bit accepted);
    int cycles;
    cycles   = 0;
    accepted = 1'b0;
    @(posedge clk_i);
    req_v_i[k]     <= 1'b1;
    req_op_i[k]    <= op;
    req_addr_i[k]  <= addr[`WH_BLOCK_ADDR_WIDTH-1:0];
    req_mask_i[k]  <= mask;
    req_wdata_i[k] <= data;
    while (!accepted && cycles < timeout_cycles) begin
      @(negedge clk_i);
      if (req_ready_o[k]) accepted = 1'b1; // taken on the coming edge
      cycles++;
    end
    @(posedge clk_i);
    req_v_i[k] <= 1'b0;
  endtask

  task automatic do_write(input int k, input wh_mem_pkg::wh_opcode_e op, input int addr,
                          input logic [`WH_BLOCK_WORDS-1:0] mask,
                          input logic [block_bits_lp-1:0] data, input string name);
    bit accepted;
    bit done;
    int cycles;
    done   = 1'b0;
    cycles = 0;
    send_request(k, op, addr, mask, data, accepted);
    while (accepted && !done && cycles < timeout_cycles) begin
      @(negedge clk_i);
      done = req_ready_o[k];
      cycles++;
    end
    @(posedge clk_i);
    if (!done) begin
      timeout_count++;
      $display("timeout in %s: client %0d did not finish its write", name, k);
    end
    model_write(addr, (op == wh_mem_pkg::op_write) ? '1 : mask, data);
    written[addr] = 1'b1;
  endtask

  task automatic do_read(input int k, input int addr, input string name);
    bit accepted;
    bit done;
    int cycles;
    done           = 1'b0;
    cycles         = 0;
    exp_block[k]   = expected_block(addr);
    exp_name[k]    = name;
    exp_pending[k] = 1'b1;
    send_request(k, wh_mem_pkg::op_read, addr, '0, '0, accepted);
    while (accepted && !done && cycles < timeout_cycles) begin
      @(negedge clk_i);
      done = resp_v_o[k];
      cycles++;
    end
    if (!done) begin
      timeout_count++;
      exp_pending[k] = 1'b0;
      $display("timeout in %s: client %0d got no fill for block %0d", name, k, addr);
    end
    @(posedge clk_i);
  endtask

  task automatic random_traffic(input int k, input int count);
    int                         blk;
    int                         sel;
    logic [`WH_BLOCK_WORDS-1:0] mask;
    string                      name;
    for (int i = 0; i < count; i++) begin
      blk  = ($unsigned($random(seed)) % (num_blocks_lp / 2)) * 2 + k; // own half of memory
      sel  = $unsigned($random(seed)) % 3;
      mask = `WH_BLOCK_WORDS'($random(seed));
      name = $sformatf("random_c%0d_%0d", k, i);
      if (!written[blk] || sel == 1) begin
        do_write(k, wh_mem_pkg::op_write, blk, '1, random_block(), name);
      end else if (sel == 2) begin
        do_write(k, wh_mem_pkg::op_write_masked, blk, mask, random_block(), name);
      end else begin
        do_read(k, blk, name);
      end
    end
  endtask

  // every fill is checked against the block expected at issue time
  always @(negedge clk_i) begin
    for (int k = 0; k < n_lp; k++) begin
      if (resp_v_o[k]) begin
        if (!exp_pending[k]) begin
          error_count++;
          $display("[FAIL] unexpected_resp_c%0d: expected resp_v_o 0, actual %b", k,
                   resp_v_o[k]);
        end else begin
          if (resp_rdata_o[k] !== exp_block[k]) begin
            error_count++;
            $display("[FAIL] %s: expected %h, actual %h", exp_name[k], exp_block[k],
                     resp_rdata_o[k]);
          end
          exp_pending[k] = 1'b0;
        end
      end
    end
  end

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    req_v_i       = '0;
    for (int k = 0; k < n_lp; k++) begin
      req_op_i[k] = wh_mem_pkg::op_read;
    end
    req_addr_i    = '0;
    req_mask_i    = '0;
    req_wdata_i   = '0;
    seed          = 32'h85a04d49;
    error_count   = 0;
    timeout_count = 0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    if (req_ready_o !== '0 || resp_v_o !== '0) begin
      error_count++;
      $display("[FAIL] after_reset: expected req_ready_o %b resp_v_o %b, actual %b %b",
               {n_lp{1'b0}}, {n_lp{1'b0}}, req_ready_o, resp_v_o);
    end

    do_write(0, wh_mem_pkg::op_write, 5, '1, random_block(), "write_read");
    do_read(0, 5, "write_read");

    do_write(0, wh_mem_pkg::op_write_masked, 5, 4'b0101, random_block(), "masked_write_c0");
    do_read(0, 5, "masked_write_c0");
    do_write(1, wh_mem_pkg::op_write_masked, 5, 4'b1000, random_block(), "masked_write_c1");
    do_read(1, 5, "masked_write_c1");

    do_write(0, wh_mem_pkg::op_write, 12, '1, random_block(), "cross_client");
    do_read(1, 12, "cross_client");

    fork
      do_read(0, 12, "contention_c0");
      do_read(1, 5, "contention_c1");
    join
    fork
      do_write(0, wh_mem_pkg::op_write, 40, '1, random_block(), "contention_wr_c0");
      do_write(1, wh_mem_pkg::op_write, 41, '1, random_block(), "contention_wr_c1");
    join
    fork
      do_read(0, 41, "contention_rd_c0");
      do_read(1, 40, "contention_rd_c1");
    join

    fork
      random_traffic(0, 100);
      random_traffic(1, 100);
    join

    repeat (4) @(posedge clk_i);
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+hw
hw/wh_mem_pkg.sv
hw/wh_link_if.sv
hw/wh_block_client.sv
hw/wh_packet_arbiter.sv
hw/wh_test_mem.sv
hw/wh_mem_top.sv
test/tb_wh_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wh_mem -f src.f -o tb_wh_mem

# the log decides the result, so a nonzero exit must not stop the script here
./obj_dir/tb_wh_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation finished without errors"
exit 0
